//--- common/fault_cfg.svh
// Project-wide constants for channel count, sample width, thresholds and timers
`ifndef FAULT_CFG_SVH
`define FAULT_CFG_SVH

// --------------------------------------------------------------------------
// Channel side
// --------------------------------------------------------------------------
`define FM_NUM_CHAN     12
`define FM_SAMPLE_W     16

// Open-circuit limit on the loop current, about 0.2 mA
`define FM_OPEN_LIMIT   16'h8045

// Diagnostic voltage window, roughly 0.82 V to 0.84 V
`define FM_DGD_LOW      16'h965D
`define FM_DGD_HIGH     16'h96FD

// --------------------------------------------------------------------------
// Supply and watchdog side
// --------------------------------------------------------------------------
// Tick every FM_TICK_MAX+1 clocks of 12.5 MHz, i.e. every 10 us
`define FM_TICK_MAX     124

// Watchdog timeout once the MSB of this counter sets (4096 ticks)
`define FM_WD_TICKS_W   13

// Consecutive low samples of pwr_ok before a power fault
`define FM_PWR_FILT_LEN 4

`endif

//--- common/chan_pkg.sv
// Channel-side types: ADC sample, per-channel bit vector, channel sample bundle
`default_nettype none

`include "fault_cfg.svh"

package chan_pkg;

    // One raw ADC conversion result
    typedef logic [`FM_SAMPLE_W-1:0] sample_t;

    // One bit per analog channel
    typedef logic [`FM_NUM_CHAN-1:0] chan_vec_t;

    // Samples of all channels as they arrive from the acquisition logic.
    // A dgd_sel bit of 1 marks the sample as a diagnostic measurement,
    // a 0 marks a normal measurement.
    typedef struct packed {
        chan_vec_t                       valid;
        chan_vec_t                       dgd_sel;
        sample_t [`FM_NUM_CHAN-1:0]      data;
    } chan_sample_t;

endpackage

`default_nettype wire

//--- common/fault_pkg.sv
// Fault-side types: RAM error sources, watchdog error sources, module status word
`default_nettype none

package fault_pkg;

    // RAM parity and ECC error sources
    typedef struct packed {
        logic       up;
        logic [1:0] slink;
        logic [1:0] txsdu;
        logic       rxsdu;
    } ram_err_t;

    // Watchdog supervision error sources
    typedef struct packed {
        logic clk;
        logic ch;
        logic com;
    } wd_err_t;

    // --------------------------------------------------------------------------
    // Module status word, 32 bits
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic [9:0] rsvd_31_22;
        logic       pwr;
        logic       wd;
        logic       ch;
        logic [3:0] rsvd_18_15;
        logic       ram;
        logic [2:0] rsvd_13_11;
        logic       rdu;
        logic       rsvd_9;
        logic       e2p;
        logic [7:0] rsvd_7_0;
    } mdu_status_t;

endpackage

`default_nettype wire

//--- chan_diag/chan_capture.sv
// Per-channel hold registers for the latest diagnostic and normal ADC sample
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module chan_capture (
    input  wire                    clk_12_5m,
    input  wire                    rst_12_5m_n,

    input  wire chan_pkg::chan_sample_t samples,

    output chan_pkg::sample_t      dgd_value  [`FM_NUM_CHAN],
    output chan_pkg::sample_t      norm_value [`FM_NUM_CHAN]
);

    // --------------------------------------------------------------------------
    // Diagnostic slot
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            for (int i = 0; i < `FM_NUM_CHAN; i++) begin
                dgd_value[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FM_NUM_CHAN; i++) begin
                if (samples.valid[i] && samples.dgd_sel[i]) begin
                    dgd_value[i] <= samples.data[i];
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Normal slot
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            for (int i = 0; i < `FM_NUM_CHAN; i++) begin
                norm_value[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FM_NUM_CHAN; i++) begin
                // Select bit low means a regular loop measurement
                if (samples.valid[i] && !samples.dgd_sel[i]) begin
                    norm_value[i] <= samples.data[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- chan_diag/chan_judge.sv
// Open-circuit and diagnostic-window comparison for every channel, registered
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module chan_judge (
    input  wire                    clk_12_5m,
    input  wire                    rst_12_5m_n,

    input  wire                    chn_dgd_en,
    input  wire chan_pkg::sample_t dgd_value  [`FM_NUM_CHAN],
    input  wire chan_pkg::sample_t norm_value [`FM_NUM_CHAN],

    output chan_pkg::chan_vec_t    chan_open_short,
    output chan_pkg::chan_vec_t    chan_dgd_err
);

    // Thresholds are shared by all channels
    localparam chan_pkg::sample_t OPEN_LIMIT = `FM_OPEN_LIMIT;
    localparam chan_pkg::sample_t DGD_LOW    = `FM_DGD_LOW;
    localparam chan_pkg::sample_t DGD_HIGH   = `FM_DGD_HIGH;

    chan_pkg::chan_vec_t open_next;
    chan_pkg::chan_vec_t dgd_next;

    // --------------------------------------------------------------------------
    // Comparators
    // --------------------------------------------------------------------------
    always_comb begin
        open_next = '0;
        dgd_next  = '0;
        for (int i = 0; i < `FM_NUM_CHAN; i++) begin
            // Loop current below the limit means a broken wire
            open_next[i] = chn_dgd_en && (norm_value[i] < OPEN_LIMIT);

            // Diagnostic voltage must sit inside the window, bounds included
            dgd_next[i] = chn_dgd_en &&
                          ((dgd_value[i] < DGD_LOW) || (dgd_value[i] > DGD_HIGH));
        end
    end

    // --------------------------------------------------------------------------
    // Result registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            chan_open_short <= '0;
            chan_dgd_err    <= '0;
        end else begin
            chan_open_short <= open_next;
            chan_dgd_err    <= dgd_next;
        end
    end

endmodule

`default_nettype wire

//--- fault_status/supply_watch.sv
// Tick divider, pwr_ok history filter and watchdog configuration timeout
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module supply_watch (
    input  wire  clk_12_5m,
    input  wire  rst_12_5m_n,

    input  wire  pwr_ok,
    input  wire  wd_cfg_en,
    input  wire  wd_cfg_done,

    output logic pwr_fault,
    output logic wd_cfg_fault
);

    localparam int TICK_W = $clog2(`FM_TICK_MAX + 1);

    typedef logic [TICK_W-1:0]           tick_cnt_t;
    typedef logic [`FM_PWR_FILT_LEN-1:0] pwr_hist_t;
    typedef logic [`FM_WD_TICKS_W-1:0]   wd_cnt_t;

    localparam tick_cnt_t TICK_MAX = tick_cnt_t'(`FM_TICK_MAX);

    tick_cnt_t tick_cnt;
    logic      tick;
    pwr_hist_t pwr_hist;
    wd_cnt_t   wd_cnt;
    logic      wd_expired;

    // --------------------------------------------------------------------------
    // 10 us tick
    // --------------------------------------------------------------------------
    assign tick = (tick_cnt == TICK_MAX);

    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + tick_cnt_t'(1);
        end
    end

    // --------------------------------------------------------------------------
    // Power-fail filter
    // --------------------------------------------------------------------------
    // History starts as all ones so no fault is seen before real samples
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            pwr_hist <= '1;
        end else if (tick) begin
            pwr_hist <= {pwr_hist[`FM_PWR_FILT_LEN-2:0], pwr_ok};
        end
    end

    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            pwr_fault <= 1'b0;
        end else begin
            pwr_fault <= (pwr_hist == '0);
        end
    end

    // --------------------------------------------------------------------------
    // Watchdog configuration timeout
    // --------------------------------------------------------------------------
    assign wd_expired = wd_cnt[`FM_WD_TICKS_W-1];

    // Saturates once the MSB sets
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            wd_cnt <= '0;
        end else if (wd_cfg_en && tick && !wd_expired) begin
            wd_cnt <= wd_cnt + wd_cnt_t'(1);
        end
    end

    // Sticky until reset
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            wd_cfg_fault <= 1'b0;
        end else if (wd_expired && !wd_cfg_done) begin
            wd_cfg_fault <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- fault_status/status_word.sv
// Fault source merging, module status word and the two summary flags
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module status_word (
    input  wire                     clk_12_5m,
    input  wire                     rst_12_5m_n,

    input  wire                     pwr_fault,
    input  wire                     wd_cfg_fault,
    input  wire fault_pkg::ram_err_t ram_err,
    input  wire fault_pkg::wd_err_t  wd_err,
    input  wire                     e2p_chip_err,
    input  wire                     rdu_fault,
    input  wire                     ch_fault,

    output fault_pkg::mdu_status_t  mdu_stus,
    output logic                    hw_fault,
    output logic                    pwr_ram_fault
);

    logic                   ram_fault;
    logic                   wd_src_fault;
    logic                   e2p_err;
    logic                   wd_fault;
    fault_pkg::mdu_status_t status_next;

    // --------------------------------------------------------------------------
    // Source registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            ram_fault    <= 1'b0;
            wd_src_fault <= 1'b0;
            e2p_err      <= 1'b0;
        end else begin
            ram_fault    <= |ram_err;
            wd_src_fault <= |wd_err;
            e2p_err      <= e2p_chip_err;
        end
    end

    // Either a supervision error or a missed configuration
    assign wd_fault = wd_src_fault || wd_cfg_fault;

    always_comb begin
        status_next     = '0;
        status_next.pwr = pwr_fault;
        status_next.wd  = wd_fault;
        status_next.ch  = ch_fault;
        status_next.ram = ram_fault;
        status_next.rdu = rdu_fault;
        status_next.e2p = e2p_err;
    end

    // --------------------------------------------------------------------------
    // Output registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m_n) begin
        if (!rst_12_5m_n) begin
            mdu_stus      <= '0;
            hw_fault      <= 1'b0;
            pwr_ram_fault <= 1'b0;
        end else begin
            mdu_stus      <= status_next;
            hw_fault      <= pwr_fault || ch_fault || ram_fault || rdu_fault ||
                             wd_cfg_fault || wd_src_fault || e2p_err;
            // Channel and RDU faults stay out of this one
            pwr_ram_fault <= pwr_fault || ram_fault || wd_src_fault || e2p_err;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fault_monitor_top.sv
// Top level of the fault monitor: channel diagnosis and module fault status
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module fault_monitor_top (
    input  wire                      clk_12_5m,
    input  wire                      rst_12_5m_n,

    // Channel samples and diagnosis enable
    input  wire chan_pkg::chan_sample_t samples,
    input  wire                      chn_dgd_en,

    // Supply and watchdog configuration
    input  wire                      pwr_ok,
    input  wire                      wd_cfg_en,
    input  wire                      wd_cfg_done,

    // External fault sources
    input  wire fault_pkg::ram_err_t  ram_err,
    input  wire fault_pkg::wd_err_t   wd_err,
    input  wire                      e2p_chip_err,
    input  wire                      rdu_fault,
    input  wire                      ch_fault,

    output chan_pkg::chan_vec_t      chan_open_short,
    output chan_pkg::chan_vec_t      chan_dgd_err,
    output fault_pkg::mdu_status_t   mdu_stus,
    output logic                     hw_fault,
    output logic                     pwr_ram_fault
);

    chan_pkg::sample_t dgd_value  [`FM_NUM_CHAN];
    chan_pkg::sample_t norm_value [`FM_NUM_CHAN];
    logic              pwr_fault;
    logic              wd_cfg_fault;

    // --------------------------------------------------------------------------
    // Channel diagnosis
    // --------------------------------------------------------------------------
    chan_capture u_chan_capture (
        .clk_12_5m   (clk_12_5m),
        .rst_12_5m_n (rst_12_5m_n),
        .samples     (samples),
        .dgd_value   (dgd_value),
        .norm_value  (norm_value)
    );

    chan_judge u_chan_judge (
        .clk_12_5m       (clk_12_5m),
        .rst_12_5m_n     (rst_12_5m_n),
        .chn_dgd_en      (chn_dgd_en),
        .dgd_value       (dgd_value),
        .norm_value      (norm_value),
        .chan_open_short (chan_open_short),
        .chan_dgd_err    (chan_dgd_err)
    );

    // --------------------------------------------------------------------------
    // Module fault status
    // --------------------------------------------------------------------------
    supply_watch u_supply_watch (
        .clk_12_5m    (clk_12_5m),
        .rst_12_5m_n  (rst_12_5m_n),
        .pwr_ok       (pwr_ok),
        .wd_cfg_en    (wd_cfg_en),
        .wd_cfg_done  (wd_cfg_done),
        .pwr_fault    (pwr_fault),
        .wd_cfg_fault (wd_cfg_fault)
    );

    status_word u_status_word (
        .clk_12_5m     (clk_12_5m),
        .rst_12_5m_n   (rst_12_5m_n),
        .pwr_fault     (pwr_fault),
        .wd_cfg_fault  (wd_cfg_fault),
        .ram_err       (ram_err),
        .wd_err        (wd_err),
        .e2p_chip_err  (e2p_chip_err),
        .rdu_fault     (rdu_fault),
        .ch_fault      (ch_fault),
        .mdu_stus      (mdu_stus),
        .hw_fault      (hw_fault),
        .pwr_ram_fault (pwr_ram_fault)
    );

endmodule

`default_nettype wire

//--- testbench/fault_monitor_properties.sv
// Concurrent checks on the fault monitor outputs, bound to the top level
`default_nettype none
`timescale 1ns/10ps

module fault_monitor_properties (
    input wire                      clk_12_5m,
    input wire                      rst_12_5m_n,
    input wire chan_pkg::chan_vec_t chan_open_short,
    input wire chan_pkg::chan_vec_t chan_dgd_err,
    input wire [31:0]               mdu_stus,
    input wire                      hw_fault,
    input wire                      pwr_ram_fault,
    input wire                      wd_cfg_fault
);

    // Bits 21..19, 14, 10 and 8 carry faults
    localparam logic [31:0] USED_BITS = 32'h0038_4500;

    reset_clears_outputs: assert property (@(posedge clk_12_5m)
        $rose(rst_12_5m_n) |-> (chan_open_short == '0) && (chan_dgd_err == '0) &&
                               (mdu_stus == '0) && !hw_fault && !pwr_ram_fault)
        else $error("Outputs not cleared by reset");

    // Sticky until the next reset
    wd_cfg_fault_sticky: assert property (@(posedge clk_12_5m) disable iff (!rst_12_5m_n)
        wd_cfg_fault |=> wd_cfg_fault)
        else $error("wd_cfg_fault fell without a reset");

    reserved_bits_zero: assert property (@(posedge clk_12_5m)
        (mdu_stus & ~USED_BITS) == '0)
        else $error("Reserved bits of mdu_stus are not zero");

endmodule

bind fault_monitor_top fault_monitor_properties u_properties (
    .clk_12_5m       (clk_12_5m),
    .rst_12_5m_n     (rst_12_5m_n),
    .chan_open_short (chan_open_short),
    .chan_dgd_err    (chan_dgd_err),
    .mdu_stus        (mdu_stus),
    .hw_fault        (hw_fault),
    .pwr_ram_fault   (pwr_ram_fault),
    .wd_cfg_fault    (wd_cfg_fault)
);

`default_nettype wire

//--- testbench/tb_fault_monitor.sv
// Testbench top for the fault monitor: clock, reset, pattern reader, stimulus, checks, report
`default_nettype none
`timescale 1ns/10ps

`include "fault_cfg.svh"

module tb_fault_monitor;

    localparam int NUM_ROWS     = 26;
    localparam int ROW_W        = 6;
    localparam int TICK_CLKS    = `FM_TICK_MAX + 1;
    localparam int LATENCY_MIN  = 3;
    localparam int CHAN_TMO     = 10;
    localparam int SRC_TMO      = 10;
    localparam int WD_WAIT_CLKS = 4200 * TICK_CLKS;
    localparam int WD_MIN_CLKS  = 4095 * TICK_CLKS;
    localparam int WD_MAX_CLKS  = 4097 * TICK_CLKS;
    localparam int SIM_LIMIT_NS = 300_000_000;

    logic                   clk_12_5m;
    logic                   rst_12_5m_n;
    chan_pkg::chan_sample_t samples;
    logic                   chn_dgd_en;
    logic                   pwr_ok;
    logic                   wd_cfg_en;
    logic                   wd_cfg_done;
    fault_pkg::ram_err_t    ram_err;
    fault_pkg::wd_err_t     wd_err;
    logic                   e2p_chip_err;
    logic                   rdu_fault;
    logic                   ch_fault;
    chan_pkg::chan_vec_t    chan_open_short;
    chan_pkg::chan_vec_t    chan_dgd_err;
    fault_pkg::mdu_status_t mdu_stus;
    logic                   hw_fault;
    logic                   pwr_ram_fault;

    logic [15:0] pat_mem [NUM_ROWS*ROW_W];
    int          err_cnt;
    int          test_pass;
    int          test_fail;
    int          err_start;
    int          cycles;
    logic        ok;
    logic        seen;

    fault_monitor_top u_dut (
        .clk_12_5m       (clk_12_5m),
        .rst_12_5m_n     (rst_12_5m_n),
        .samples         (samples),
        .chn_dgd_en      (chn_dgd_en),
        .pwr_ok          (pwr_ok),
        .wd_cfg_en       (wd_cfg_en),
        .wd_cfg_done     (wd_cfg_done),
        .ram_err         (ram_err),
        .wd_err          (wd_err),
        .e2p_chip_err    (e2p_chip_err),
        .rdu_fault       (rdu_fault),
        .ch_fault        (ch_fault),
        .chan_open_short (chan_open_short),
        .chan_dgd_err    (chan_dgd_err),
        .mdu_stus        (mdu_stus),
        .hw_fault        (hw_fault),
        .pwr_ram_fault   (pwr_ram_fault)
    );

    // 200 ns period
    always #100 clk_12_5m = ~clk_12_5m;

    initial begin
        #(SIM_LIMIT_NS);
        $display("Simulation time limit reached before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic align_to_drive();
        @(posedge clk_12_5m);
        #20;
    endtask

    task automatic apply_reset();
        align_to_drive();
        rst_12_5m_n = 1'b0;
        repeat (2) @(posedge clk_12_5m);
        #20;
        rst_12_5m_n = 1'b1;
    endtask

    task automatic finish_test(input string name, input int err_at_start);
        if (err_cnt == err_at_start) begin
            test_pass++;
            $display("Test %s: passed", name);
        end else begin
            test_fail++;
            $display("Test %s: failed with %0d errors", name, err_cnt - err_at_start);
        end
    endtask

    // Far above the open limit and the diagnostic window
    function automatic chan_pkg::sample_t filler_value();
        return chan_pkg::sample_t'(16'hC000 + ($urandom() % 16'h3000));
    endfunction

    task automatic wait_chan(input int ch, input logic exp_open, input logic exp_dgd,
                             output logic done);
        int n;
        n = 0;
        done = 1'b0;
        while (!done && n < CHAN_TMO) begin
            @(negedge clk_12_5m);
            n++;
            done = (n >= LATENCY_MIN) && (chan_open_short[ch] === exp_open) &&
                   (chan_dgd_err[ch] === exp_dgd);
        end
        if (!done) begin
            $display("Timed out after %0d cycles waiting for the flags of channel %0d", n, ch);
        end
    endtask

    task automatic wait_status(input logic [31:0] exp_word, input logic exp_hw,
                               input logic exp_pr, input int max_cycles,
                               output int n, output logic done);
        n = 0;
        done = 1'b0;
        while (!done && n < max_cycles) begin
            @(negedge clk_12_5m);
            n++;
            done = (mdu_stus === exp_word) && (hw_fault === exp_hw) &&
                   (pwr_ram_fault === exp_pr);
        end
        if (!done) begin
            $display("Timed out after %0d cycles waiting for status word %h", n, exp_word);
        end
    endtask

    task automatic expect_status(input string what, input logic [31:0] exp_word,
                                 input logic exp_hw, input logic exp_pr, input int max_cycles);
        int   n;
        logic done;
        wait_status(exp_word, exp_hw, exp_pr, max_cycles, n, done);
        assert (done) else begin
            $display("[ERROR] %0t: %s status %h hw %b pwr_ram %b, expected %h %b %b",
                     $time, what, mdu_stus, hw_fault, pwr_ram_fault, exp_word, exp_hw, exp_pr);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Channel stimulus
    // ------------------------------------------------------------------------
    task automatic run_row(input int row);
        int                  ch;
        logic                sel;
        logic [15:0]         value;
        logic                en;
        logic                exp_open;
        logic                exp_dgd;
        logic                done;
        logic                en_before;
        chan_pkg::chan_vec_t open_before;
        chan_pkg::chan_vec_t dgd_before;
        chan_pkg::chan_vec_t others;
        ch       = int'(pat_mem[row*ROW_W]);
        sel      = pat_mem[row*ROW_W+1][0];
        value    = pat_mem[row*ROW_W+2];
        en       = pat_mem[row*ROW_W+3][0];
        exp_open = pat_mem[row*ROW_W+4][0];
        exp_dgd  = pat_mem[row*ROW_W+5][0];
        align_to_drive();
        open_before = chan_open_short;
        dgd_before  = chan_dgd_err;
        en_before   = chn_dgd_en;
        others      = ~(chan_pkg::chan_vec_t'(1) << ch);
        samples.valid   = '0;
        samples.dgd_sel = '0;
        for (int i = 0; i < `FM_NUM_CHAN; i++) begin
            samples.data[i] = filler_value();
        end
        samples.valid[ch]   = 1'b1;
        samples.dgd_sel[ch] = sel;
        samples.data[ch]    = value;
        chn_dgd_en          = en;
        wait_chan(ch, exp_open, exp_dgd, done);
        assert (done) else begin
            $display("[ERROR] %0t: row %0d channel %0d open %b dgd %b, expected %b %b",
                     $time, row, ch, chan_open_short[ch], chan_dgd_err[ch], exp_open, exp_dgd);
            err_cnt++;
        end
        // Filler data without valid must leave the other channels alone
        if (en == en_before) begin
            assert (((chan_open_short & others) === (open_before & others)) &&
                    ((chan_dgd_err & others) === (dgd_before & others))) else begin
                $display("[ERROR] %0t: row %0d other channels open %h dgd %h, expected %h %h",
                         $time, row, chan_open_short & others, chan_dgd_err & others,
                         open_before & others, dgd_before & others);
                err_cnt++;
            end
        end
        align_to_drive();
        samples.valid = '0;
    endtask

    task automatic check_dgd_disabled();
        int   n;
        logic done;
        align_to_drive();
        chn_dgd_en      = 1'b0;
        samples.valid   = '1;
        samples.dgd_sel = chan_pkg::chan_vec_t'($urandom());
        for (int i = 0; i < `FM_NUM_CHAN; i++) begin
            // Well below every bound so an enabled judge would flag them
            samples.data[i] = chan_pkg::sample_t'($urandom() % 256);
        end
        n = 0;
        done = 1'b0;
        while (!done && n < CHAN_TMO) begin
            @(negedge clk_12_5m);
            n++;
            done = (n >= LATENCY_MIN) && (chan_open_short === '0) && (chan_dgd_err === '0);
        end
        assert (done) else begin
            $display("[ERROR] %0t: flags %h %h with diagnosis disabled, expected zero",
                     $time, chan_open_short, chan_dgd_err);
            err_cnt++;
        end
        // Other slot too
        align_to_drive();
        samples.dgd_sel = ~samples.dgd_sel;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_12_5m);
            assert ((chan_open_short === '0) && (chan_dgd_err === '0)) else begin
                $display("[ERROR] %0t: flags %h %h rose with diagnosis disabled",
                         $time, chan_open_short, chan_dgd_err);
                err_cnt++;
            end
        end
        align_to_drive();
        samples.valid = '0;
    endtask

    // ------------------------------------------------------------------------
    // Fault source index 0..5 ram_err, 6..8 wd_err, 9 e2p, 10 rdu and 11 ch
    // ------------------------------------------------------------------------
    task automatic set_source(input int src, input logic val);
        align_to_drive();
        if (src < 6) begin
            ram_err = fault_pkg::ram_err_t'(val ? (6'b1 << src) : 6'b0);
        end else if (src < 9) begin
            wd_err = fault_pkg::wd_err_t'(val ? (3'b1 << (src - 6)) : 3'b0);
        end else if (src == 9) begin
            e2p_chip_err = val;
        end else if (src == 10) begin
            rdu_fault = val;
        end else begin
            ch_fault = val;
        end
    endtask

    function automatic int source_bit(input int src);
        if (src < 6) return 14;
        if (src < 9) return 20;
        if (src == 9) return 8;
        if (src == 10) return 10;
        return 19;
    endfunction

    function automatic string source_name(input int src);
        if (src < 6) return $sformatf("ram_err[%0d]", src);
        if (src < 9) return $sformatf("wd_err[%0d]", src - 6);
        if (src == 9) return "e2p_chip_err";
        if (src == 10) return "rdu_fault";
        return "ch_fault";
    endfunction

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(60914));
        clk_12_5m    = 1'b0;
        rst_12_5m_n  = 1'b0;
        samples      = '0;
        chn_dgd_en   = 1'b0;
        pwr_ok       = 1'b1;
        wd_cfg_en    = 1'b0;
        wd_cfg_done  = 1'b0;
        ram_err      = '0;
        wd_err       = '0;
        e2p_chip_err = 1'b0;
        rdu_fault    = 1'b0;
        ch_fault     = 1'b0;
        err_cnt      = 0;
        test_pass    = 0;
        test_fail    = 0;
        $readmemh("testbench/fault_patterns.txt", pat_mem);
        repeat (2) @(posedge clk_12_5m);
        #20;
        rst_12_5m_n = 1'b1;

        err_start = err_cnt;
        if (pat_mem[0] === 16'hxxxx) begin
            $display("Pattern file could not be read");
            err_cnt++;
        end else begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                run_row(r);
            end
        end
        finish_test("pattern rows", err_start);

        err_start = err_cnt;
        check_dgd_disabled();
        finish_test("diagnosis disabled", err_start);

        err_start = err_cnt;
        align_to_drive();
        pwr_ok = 1'b0;
        expect_status("power fail", 32'h0020_0000, 1'b1, 1'b1, 6 * TICK_CLKS);
        align_to_drive();
        pwr_ok = 1'b1;
        repeat (TICK_CLKS) @(posedge clk_12_5m);
        #20;
        pwr_ok = 1'b0;
        expect_status("power restore", 32'h0, 1'b0, 1'b0, 2 * TICK_CLKS);
        align_to_drive();
        pwr_ok = 1'b1;
        finish_test("power fail filter", err_start);

        for (int s = 0; s < 12; s++) begin
            err_start = err_cnt;
            set_source(s, 1'b1);
            expect_status(source_name(s), 32'h1 << source_bit(s), 1'b1, s < 10, SRC_TMO);
            set_source(s, 1'b0);
            expect_status(source_name(s), 32'h0, 1'b0, 1'b0, SRC_TMO);
            finish_test(source_name(s), err_start);
        end

        // Configuration confirmed in time
        err_start = err_cnt;
        apply_reset();
        align_to_drive();
        wd_cfg_done = 1'b1;
        wd_cfg_en   = 1'b1;
        seen        = 1'b0;
        for (int i = 0; i < WD_WAIT_CLKS; i++) begin
            @(negedge clk_12_5m);
            if (mdu_stus[20]) seen = 1'b1;
        end
        assert (!seen) else begin
            $display("[ERROR] %0t: watchdog status bit set although configuration was done",
                     $time);
            err_cnt++;
        end
        finish_test("watchdog configured", err_start);

        // Counter is saturated now so start over from reset
        err_start = err_cnt;
        apply_reset();
        align_to_drive();
        wd_cfg_done = 1'b0;
        wd_cfg_en   = 1'b1;
        wait_status(32'h0010_0000, 1'b1, 1'b0, WD_WAIT_CLKS, cycles, ok);
        assert (ok && cycles >= WD_MIN_CLKS && cycles <= WD_MAX_CLKS) else begin
            $display("[ERROR] %0t: watchdog timeout after %0d cycles, status %h, expected %0d",
                     $time, cycles, mdu_stus, 4096 * TICK_CLKS);
            err_cnt++;
        end
        align_to_drive();
        wd_cfg_en = 1'b0;
        seen      = 1'b0;
        for (int i = 0; i < 2 * TICK_CLKS; i++) begin
            @(negedge clk_12_5m);
            if (!mdu_stus[20]) seen = 1'b1;
        end
        assert (!seen) else begin
            $display("[ERROR] %0t: watchdog status bit cleared after wd_cfg_en dropped", $time);
            err_cnt++;
        end
        finish_test("watchdog timeout", err_start);

        $display("Tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/fault_patterns.txt
// Columns: channel, select (1 = diagnostic), sample, dgd_en, expected open, expected dgd error
// Held values start at zero after reset, the other slot of a channel keeps its last value
0 0 8044 1 1 1
0 0 8045 1 0 1
0 1 965D 1 0 0
0 1 96FD 1 0 0
0 1 965C 1 0 1
0 1 96FE 1 0 1
0 0 0000 1 1 1
0 0 FFFF 1 0 1
0 1 96A0 1 0 0
0 1 96A0 0 0 0
5 0 8046 1 0 1
5 1 0000 1 0 1
5 1 FFFF 1 0 1
5 1 9700 1 0 1
5 1 96FC 1 0 0
5 0 7FFF 1 1 0
5 0 1234 0 0 0
B 1 965E 1 1 0
B 0 8045 1 0 0
B 0 8044 1 1 0
B 1 965D 0 0 0
B 1 965D 1 1 0
B 0 C000 1 0 0
7 1 96FD 1 1 0
7 0 8045 1 0 0
7 1 96FE 1 0 1

//--- project.f
+incdir+common
common/chan_pkg.sv
common/fault_pkg.sv
chan_diag/chan_capture.sv
chan_diag/chan_judge.sv
fault_status/supply_watch.sv
fault_status/status_word.sv
verilog/fault_monitor_top.sv
testbench/fault_monitor_properties.sv
testbench/tb_fault_monitor.sv
